/* sccb_pkg.sv */
/* Shared SCCB timing constants, operation and state encodings, command/response types.
   Referenced by scoped name from the master, top level and testbench. */
`default_nettype none

package sccb_pkg;

  // Bus timing
  localparam int QUARTER_DIV = 25;  // SCCB_CLK cycles per quarter bit, 100 per SIO_C period
  localparam int DEV_ID_W    = 7;   // Device ID without R/W bit
  localparam int PHASE_BITS  = 9;   // 8 data bits + don't-care bit

  // Operation, value doubles as R/W bit of the second ID phase
  typedef enum logic {
    SCCB_WRITE = 1'b0,
    SCCB_READ  = 1'b1
  } sccb_op_e;

  // Transaction FSM states
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,  // Bus released, SIO_C high
    ST_START       = 3'd1,  // SIO_D falls under high SIO_C
    ST_PHASE       = 3'd2,  // Nine-bit phases
    ST_STOP        = 3'd3,  // SIO_D rises under high SIO_C
    ST_RESTART_GAP = 3'd4   // Idle bit between read passes
  } sccb_state_e;

  // Command, 24 bits
  typedef struct packed {
    sccb_op_e              op;
    logic [DEV_ID_W-1:0]   dev_id;
    logic [7:0]            reg_addr;
    logic [7:0]            wr_data;   // Ignored for reads
  } sccb_cmd_t;

  // Response, last byte read
  typedef struct packed {
    logic [7:0] rd_data;
  } sccb_rsp_t;

endpackage

`default_nettype wire

/* sccb_tick_gen.sv */
/* Quarter-bit tick generator for the SCCB master.
   Runs only while run is high and restarts on a clean bit boundary. */
`timescale 1ns/1ps
`default_nettype none

module sccb_tick_gen (
  input  logic       SCCB_CLK,
  input  logic       RST,
  input  logic       run,      // High for the whole transaction
  output logic       tick,     // One cycle at the end of each quarter
  output logic [1:0] quarter   // Quarter within current bit
);

  logic [$clog2(sccb_pkg::QUARTER_DIV)-1:0] div_cnt;
  logic                                     div_last;

  // Last cycle of a quarter
  assign div_last = (div_cnt == $bits(div_cnt)'(sccb_pkg::QUARTER_DIV - 1));
  assign tick     = run && div_last;

  always_ff @(posedge SCCB_CLK or negedge RST) begin
    if (!RST) begin
      div_cnt <= '0;
      quarter <= 2'd0;
    end else if (!run) begin
      // Held clear between transactions
      div_cnt <= '0;
      quarter <= 2'd0;
    end else if (div_last) begin
      div_cnt <= '0;
      quarter <= quarter + 2'd1;  // Wraps 3 -> 0 at bit end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sccb_master.sv */
/* SCCB 2-wire transaction engine: start, 9-bit phases, stop and read restart.
   Drives SIO_C and the SIO_D enable/data pair, samples read data from the pin. */
`timescale 1ns/1ps
`default_nettype none

module sccb_master (
  input  logic                SCCB_CLK,
  input  logic                RST,
  input  logic                req,       // One-cycle command strobe
  input  sccb_pkg::sccb_cmd_t cmd,
  input  logic                tick,
  input  logic [1:0]          quarter,
  input  logic                sda_in,    // Resolved SIO_D
  output logic                run,
  output logic                busy,
  output logic                done,
  output logic                SIO_C,
  output logic                sda_out,
  output logic                sda_oe,
  output sccb_pkg::sccb_rsp_t rsp
);

  sccb_pkg::sccb_state_e                   state;
  sccb_pkg::sccb_cmd_t                     cmd_q;     // Latched command
  logic [1:0]                              phase_cnt; // 0 ID, 1 addr/read byte, 2 data
  logic [$clog2(sccb_pkg::PHASE_BITS)-1:0] bit_cnt;
  logic                                    rd_pass;   // Second pass of a read
  logic [7:0]                              shift_q;   // Transmit shifter
  logic [7:0]                              rd_shift;  // Receive shifter
  logic [7:0]                              tx_byte;
  logic [7:0]                              tx_bits;
  logic                                    accept;
  logic                                    dc_bit;
  logic                                    rd_byte;
  logic                                    last_phase;
  logic                                    sclk_next;
  logic                                    q0_tick, q1_tick, q2_tick, q3_tick;

  assign accept  = req && !busy;  // Requests while busy are dropped
  assign run     = busy;
  assign q0_tick = tick && (quarter == 2'd0);  // Mid-low, data update
  assign q1_tick = tick && (quarter == 2'd1);
  assign q2_tick = tick && (quarter == 2'd2);  // Mid-high, data sample
  assign q3_tick = tick && (quarter == 2'd3);  // Bit end

  assign dc_bit  = (bit_cnt == $bits(bit_cnt)'(sccb_pkg::PHASE_BITS - 1));
  assign rd_byte = rd_pass && (phase_cnt == 2'd1);

  // Write has ID/addr/data, both read passes stop after two phases
  assign last_phase = (cmd_q.op == sccb_pkg::SCCB_WRITE) ? (phase_cnt == 2'd2)
                                                         : (phase_cnt == 2'd1);

  // Byte for the current phase, R/W bit set only on the second read pass
  always_comb begin
    case (phase_cnt)
      2'd0:    tx_byte = {cmd_q.dev_id, rd_pass};
      2'd1:    tx_byte = cmd_q.reg_addr;
      default: tx_byte = cmd_q.wr_data;
    endcase
  end

  // First bit of a phase comes straight from the mux
  assign tx_bits = (bit_cnt == '0) ? tx_byte : shift_q;

  // SIO_C shape per state
  always_comb begin
    case (state)
      sccb_pkg::ST_START: sclk_next = (quarter != 2'd3);  // High, drops for last quarter
      sccb_pkg::ST_PHASE,
      sccb_pkg::ST_STOP:  sclk_next = quarter[1];          // Low q0/q1, high q2/q3
      default:            sclk_next = 1'b1;
    endcase
  end

  always_ff @(posedge SCCB_CLK or negedge RST) begin
    if (!RST) begin
      state     <= sccb_pkg::ST_IDLE;
      phase_cnt <= 2'd0;
      bit_cnt   <= '0;
      rd_pass   <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      SIO_C     <= 1'b1;
      sda_out   <= 1'b1;
      sda_oe    <= 1'b0;  // Bus released
    end else begin
      done  <= 1'b0;
      SIO_C <= sclk_next;
      case (state)
        sccb_pkg::ST_IDLE: begin
          if (accept) begin
            state     <= sccb_pkg::ST_START;
            busy      <= 1'b1;
            rd_pass   <= 1'b0;
            phase_cnt <= 2'd0;
            bit_cnt   <= '0;
            sda_oe    <= 1'b1;  // Take the bus at the idle level
            sda_out   <= 1'b1;
          end
        end
        sccb_pkg::ST_START: begin
          if (q1_tick) sda_out <= 1'b0;  // Start edge, SIO_C high
          if (q3_tick) state <= sccb_pkg::ST_PHASE;
        end
        sccb_pkg::ST_PHASE: begin
          if (q0_tick) begin
            if (dc_bit) begin
              // NA bit after read byte, otherwise release
              sda_oe  <= rd_byte;
              sda_out <= 1'b1;
            end else begin
              sda_oe  <= !rd_byte;  // Slave drives the read byte
              sda_out <= tx_bits[7];
            end
          end
          if (q3_tick) begin
            if (!dc_bit) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else begin
              bit_cnt <= '0;
              if (last_phase) state <= sccb_pkg::ST_STOP;
              else phase_cnt <= phase_cnt + 2'd1;
            end
          end
        end
        sccb_pkg::ST_STOP: begin
          if (q0_tick) begin
            sda_oe  <= 1'b1;
            sda_out <= 1'b0;  // Low while SIO_C low
          end
          if (q2_tick) sda_out <= 1'b1;  // Stop edge
          if (q3_tick) begin
            sda_oe <= 1'b0;
            if (cmd_q.op == sccb_pkg::SCCB_READ && !rd_pass) begin
              state     <= sccb_pkg::ST_RESTART_GAP;
              rd_pass   <= 1'b1;
              phase_cnt <= 2'd0;
            end else begin
              state <= sccb_pkg::ST_IDLE;
              busy  <= 1'b0;  // Falls with done
              done  <= 1'b1;
            end
          end
        end
        sccb_pkg::ST_RESTART_GAP: begin
          // One idle bit, then restart at the released level
          if (q3_tick) begin
            state   <= sccb_pkg::ST_START;
            sda_oe  <= 1'b1;
            sda_out <= 1'b1;
          end
        end
        default: state <= sccb_pkg::ST_IDLE;
      endcase
    end
  end

  // Payload path
  always_ff @(posedge SCCB_CLK) begin
    if (accept) cmd_q <= cmd;
    if (state == sccb_pkg::ST_PHASE && q0_tick && !dc_bit)
      shift_q <= {tx_bits[6:0], 1'b0};  // MSB first
    if (state == sccb_pkg::ST_PHASE && q2_tick && rd_byte && !dc_bit)
      rd_shift <= {rd_shift[6:0], sda_in};
    if (state == sccb_pkg::ST_STOP && q3_tick && rd_pass)
      rsp.rd_data <= rd_shift;  // Only reads update rsp
  end

endmodule

`default_nettype wire

/* sccb_top.sv */
/* SCCB master top level with the tick generator, transaction engine and SIO_D pin.
   Issue cmd with a one-cycle req while busy is low, then wait for done. */
`timescale 1ns/1ps
`default_nettype none

module sccb_top (
  input  logic                SCCB_CLK,
  input  logic                RST,
  input  logic                req,
  input  sccb_pkg::sccb_cmd_t cmd,
  output logic                busy,
  output logic                done,
  output sccb_pkg::sccb_rsp_t rsp,
  output logic                SIO_C,
  inout  wire                 sio_d   // Needs external pull-up
);

  logic       run;
  logic       tick;
  logic [1:0] quarter;
  logic       sda_out;
  logic       sda_oe;

  // Open pin unless the master drives it
  assign sio_d = sda_oe ? sda_out : 1'bz;

  sccb_tick_gen u_tick_gen (
    .SCCB_CLK (SCCB_CLK),
    .RST      (RST),
    .run      (run),
    .tick     (tick),
    .quarter  (quarter)
  );

  sccb_master u_master (
    .SCCB_CLK (SCCB_CLK),
    .RST      (RST),
    .req      (req),
    .cmd      (cmd),
    .tick     (tick),
    .quarter  (quarter),
    .sda_in   (sio_d),     // Resolved pin level
    .run      (run),
    .busy     (busy),
    .done     (done),
    .SIO_C    (SIO_C),
    .sda_out  (sda_out),
    .sda_oe   (sda_oe),
    .rsp      (rsp)
  );

endmodule

`default_nettype wire

/* sccb_cam_model.sv */
/* Behavioral SCCB camera slave for simulation, answers a single device ID.
   Registers preload to the inverted address and are read back onto sio_d. */
`timescale 1ns/1ps
`default_nettype none

module sccb_cam_model (
  input  wire SIO_C,
  inout  wire sio_d
);

  localparam logic [6:0] CAM_ID = 7'h30;

  logic [7:0] regs [256];
  logic [7:0] rx_byte;
  logic [3:0] bit_cnt;
  logic [1:0] phase;
  logic [7:0] addr;
  logic [3:0] rd_bit;
  logic       active;    // Between start and stop
  logic       wr_mode;   // Our ID with R/W low
  logic       rd_mode;   // Our ID with R/W high, read byte pending
  logic       drive_en;
  logic       drive_val;

  assign sio_d = drive_en ? drive_val : 1'bz;

  initial begin
    for (int i = 0; i < 256; i++) regs[i] = ~i[7:0];  // Preload rule
    active   = 1'b0;
    wr_mode  = 1'b0;
    rd_mode  = 1'b0;
    drive_en = 1'b0;
    bit_cnt  = '0;
    phase    = '0;
  end

  // Start, SIO_D falls under high SIO_C
  always @(negedge sio_d) begin
    if (SIO_C === 1'b1) begin
      active   = 1'b1;
      bit_cnt  = '0;
      phase    = '0;
      rd_mode  = 1'b0;
      drive_en = 1'b0;
    end
  end

  // Stop, SIO_D rises under high SIO_C
  always @(posedge sio_d) begin
    if (SIO_C === 1'b1) begin
      active   = 1'b0;
      rd_mode  = 1'b0;
      drive_en = 1'b0;
    end
  end

  // Bits are stable while SIO_C is high
  always @(posedge SIO_C) begin
    if (active) begin
      if (bit_cnt < 4'd8) rx_byte = {rx_byte[6:0], sio_d};
      bit_cnt = bit_cnt + 4'd1;
      if (bit_cnt == 4'd9) begin  // Don't-care bit done, phase complete
        bit_cnt = '0;
        case (phase)
          2'd0: begin
            wr_mode = (rx_byte[7:1] == CAM_ID) && !rx_byte[0];
            rd_mode = (rx_byte[7:1] == CAM_ID) && rx_byte[0];
            rd_bit  = '0;
          end
          2'd1: begin
            if (wr_mode) addr = rx_byte;
            rd_mode = 1'b0;
          end
          2'd2: if (wr_mode) regs[addr] = rx_byte;
          default: ;
        endcase
        phase = phase + 2'd1;
      end
    end
  end

  // Read byte goes out MSB first while SIO_C is low, released on the NA bit
  always @(negedge SIO_C) begin
    if (rd_mode && rd_bit < 4'd8) begin
      drive_en  = 1'b1;
      drive_val = regs[addr][3'd7 - rd_bit[2:0]];
      rd_bit    = rd_bit + 4'd1;
    end else begin
      drive_en = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* sccb_assertions.sv */
/* Concurrent bus protocol and handshake checks for the SCCB master.
   Bound into sccb_master; failures are counted in fail_cnt for the testbench. */
`timescale 1ns/1ps
`default_nettype none

module sccb_assertions (
  input logic                  SCCB_CLK,
  input logic                  RST,
  input logic                  req,
  input logic                  busy,
  input logic                  done,
  input logic                  SIO_C,
  input logic                  sda_in,
  input logic                  sda_oe,
  input sccb_pkg::sccb_state_e state
);

  int fail_cnt = 0;

  // Idle bus: SIO_C high, SIO_D released and pulled high
  a_idle_bus: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    !busy |-> (SIO_C && sda_in && !sda_oe))
    else begin $error("idle bus levels wrong"); fail_cnt++; end

  // Falling SIO_D under high SIO_C only as a start
  a_start_edge: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    (busy && SIO_C && $past(SIO_C) && $fell(sda_in)) |-> state == sccb_pkg::ST_START)
    else begin $error("SIO_D fell with SIO_C high outside start"); fail_cnt++; end

  // Rising SIO_D under high SIO_C only as a stop
  a_stop_edge: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    (busy && SIO_C && $past(SIO_C) && $rose(sda_in)) |-> state == sccb_pkg::ST_STOP)
    else begin $error("SIO_D rose with SIO_C high outside stop"); fail_cnt++; end

  a_busy_rise: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    (req && !busy) |=> busy)
    else begin $error("busy did not rise after accepted req"); fail_cnt++; end

  a_done_one_cycle: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    done |=> !done)
    else begin $error("done longer than one cycle"); fail_cnt++; end

  a_done_with_busy: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    $fell(busy) |-> done)
    else begin $error("busy fell without done"); fail_cnt++; end

  a_done_idle: assert property (@(posedge SCCB_CLK) disable iff (!RST)
    done |-> (!busy && $past(busy)))
    else begin $error("done outside end of transaction"); fail_cnt++; end

endmodule

bind sccb_master sccb_assertions u_sccb_assertions (
  .SCCB_CLK (SCCB_CLK),
  .RST      (RST),
  .req      (req),
  .busy     (busy),
  .done     (done),
  .SIO_C    (SIO_C),
  .sda_in   (sda_in),
  .sda_oe   (sda_oe),
  .state    (state)
);

`default_nettype wire

/* tb_sccb.sv */
/* Testbench for sccb_top with a camera model on a pulled-up SIO_D.
   Read values are checked here, bus timing and handshakes by the bound assertions. */
`timescale 1ns/1ps
`default_nettype none

module tb_sccb;

  localparam int         CLK_PERIOD  = 100;
  localparam int         DRIVE_DLY   = 10;
  localparam int         BIT_CYCLES  = 4 * sccb_pkg::QUARTER_DIV;
  localparam int         NUM_CMDS    = 47;               // Accepted commands over all tests
  localparam int         DONE_LIMIT  = 45 * BIT_CYCLES;  // Longer than a read
  localparam longint     WATCHDOG_NS = longint'(NUM_CMDS) * 40 * BIT_CYCLES * CLK_PERIOD * 12 / 10;
  localparam logic [6:0] CAM_ID      = 7'h30;

  logic                SCCB_CLK;
  logic                RST;
  logic                req;
  sccb_pkg::sccb_cmd_t cmd;
  logic                busy;
  logic                done;
  sccb_pkg::sccb_rsp_t rsp;
  logic                SIO_C;
  tri1                 sio_d;     // Bus pull-up

  integer     seed;
  int         errors;
  int         tests_run;
  int         tests_bad;
  int         done_cnt;
  int         err_mark;
  logic [7:0] shadow [256];       // Expected register contents
  bit         written [256];
  logic [7:0] wr_addrs [$];
  logic [31:0] rnd;
  logic [7:0] addr;
  logic [7:0] data;

  sccb_top u_sccb_top (
    .SCCB_CLK (SCCB_CLK),
    .RST      (RST),
    .req      (req),
    .cmd      (cmd),
    .busy     (busy),
    .done     (done),
    .rsp      (rsp),
    .SIO_C    (SIO_C),
    .sio_d    (sio_d)
  );

  sccb_cam_model u_cam (
    .SIO_C (SIO_C),
    .sio_d (sio_d)
  );

  initial begin
    SCCB_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) SCCB_CLK = ~SCCB_CLK;
  end

  always @(negedge SCCB_CLK) if (RST && done) done_cnt++;

  function automatic int total_errors();
    return errors + u_sccb_top.u_master.u_sccb_assertions.fail_cnt;
  endfunction

  task automatic send_cmd(input sccb_pkg::sccb_op_e op, input logic [6:0] id,
                          input logic [7:0] a, input logic [7:0] d);
    @(posedge SCCB_CLK);
    #DRIVE_DLY;
    cmd.op       = op;
    cmd.dev_id   = id;
    cmd.reg_addr = a;
    cmd.wr_data  = d;
    req          = 1'b1;
    @(posedge SCCB_CLK);
    #DRIVE_DLY;
    req = 1'b0;           // One-cycle strobe
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(negedge SCCB_CLK);
      n++;
    end while (!done && n < DONE_LIMIT);
    if (!done) begin
      $display("no done pulse within %0d cycles", DONE_LIMIT);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [6:0] id, input logic [7:0] a, input logic [7:0] d);
    send_cmd(sccb_pkg::SCCB_WRITE, id, a, d);
    wait_done();
    if (id == CAM_ID) begin  // Other IDs leave the camera untouched
      shadow[a]  = d;
      written[a] = 1'b1;
    end
  endtask

  task automatic read_check(input logic [6:0] id, input logic [7:0] a);
    logic [7:0] exp;
    if (id != CAM_ID) exp = 8'hff;     // Nobody answers, pull-up
    else if (written[a]) exp = shadow[a];
    else exp = ~a;                     // Camera preload
    send_cmd(sccb_pkg::SCCB_READ, id, a, 8'h00);
    wait_done();
    assert (rsp.rd_data === exp)
      else begin
        $display("ERR rsp.rd_data addr %02h expected %02h got %02h", a, exp, rsp.rd_data);
        errors++;
      end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() != err_mark) tests_bad++;
    $display("test %0d %s: %s", tests_run, name, (total_errors() != err_mark) ? "bad" : "ok");
    err_mark = total_errors();
  endtask

  initial begin
    seed      = 32'h739a172f;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;
    done_cnt  = 0;
    err_mark  = 0;
    RST       = 1'b0;
    req       = 1'b0;
    cmd       = '0;
    repeat (5) @(posedge SCCB_CLK);
    #DRIVE_DLY RST = 1'b1;

    repeat (20) @(negedge SCCB_CLK);
    assert (SIO_C === 1'b1 && sio_d === 1'b1 && busy === 1'b0 && done === 1'b0)
      else begin
        $display("bus or handshake not idle after reset");
        errors++;
      end
    end_test("reset idle levels");

    write_reg(CAM_ID, 8'ha5, 8'h3c);
    read_check(CAM_ID, 8'ha5);
    end_test("write then read back");

    for (int i = 0; i < 20; i++) begin
      rnd  = $random(seed);
      addr = rnd[7:0];
      data = rnd[15:8];
      write_reg(CAM_ID, addr, data);
      wr_addrs.push_back(addr);
      rnd = $random(seed);
      if (i % 4 == 3) addr = rnd[7:0];  // Often never written
      else addr = wr_addrs[rnd[15:0] % wr_addrs.size()];
      read_check(CAM_ID, addr);
    end
    end_test("random write and read");

    write_reg(7'h21, 8'h10, 8'h55);
    read_check(7'h21, 8'h10);
    read_check(CAM_ID, 8'h10);
    end_test("foreign device ID");

    err_mark = total_errors();
    send_cmd(sccb_pkg::SCCB_WRITE, CAM_ID, 8'h5a, 8'h11);
    done_cnt = 0;  // Previous done already counted, this write still running
    repeat (5 * BIT_CYCLES) @(posedge SCCB_CLK);
    send_cmd(sccb_pkg::SCCB_WRITE, CAM_ID, 8'h5a, 8'hee);  // Lands while busy
    wait_done();
    shadow[8'h5a]  = 8'h11;
    written[8'h5a] = 1'b1;
    repeat (3 * BIT_CYCLES) @(negedge SCCB_CLK);
    assert (done_cnt == 1 && !busy)
      else begin
        $display("request while busy was not ignored, %0d done pulses", done_cnt);
        errors++;
      end
    read_check(CAM_ID, 8'h5a);
    end_test("request while busy");

    $display("tests %0d, bad %0d, errors %0d", tests_run, tests_bad, total_errors());
    if (total_errors() == 0 && tests_bad == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Every command bounded by a full read length plus margin
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
sccb_pkg.sv
sccb_tick_gen.sv
sccb_master.sv
sccb_top.sv
sccb_cam_model.sv
sccb_assertions.sv
tb_sccb.sv
